//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for 10 cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- dv/tb_fp_subsys.sv
`timescale 1ns/1ps

`include "fp_consts.svh"

module tb_fp_subsys;

  localparam int TIMEOUT_CYCLES = 200;

  logic              clk;
  logic              rst_n;
  logic              issue_valid;
  logic              issue_ready;
  fp_pkg::fp_op_e    issue_op;
  fp_pkg::fp_addr_t  issue_rd;
  fp_pkg::fp_addr_t  issue_rs1;
  fp_pkg::fp_addr_t  issue_rs2;
  fp_pkg::fp_word_t  issue_int_data;
  logic              resp_valid;
  logic              resp_ready;
  fp_pkg::fp_addr_t  resp_rd;
  fp_pkg::fp_word_t  resp_data;
  fp_pkg::fp_addr_t  dbg_addr;
  fp_pkg::fp_word_t  dbg_data;
  logic              status_clr;
  fp_pkg::fp_flags_t flags;
  fp_pkg::fp_cnt_t   retired_count;

  // Shadow copy of the register file updated in issue order
  logic [`FP_XLEN-1:0] shadow [`FP_NREGS];

  // Expected responses with the oldest first
  logic [`FP_XLEN-1:0] exp_data_q [$];
  logic [`FP_AW-1:0]   exp_rd_q [$];
  logic                exp_nv_q [$];

  // Status model and bookkeeping for the checker
  logic [4:0]           exp_flags;
  logic [`FP_CNT_W-1:0] exp_count;
  logic [`FP_XLEN-1:0]  exp_data;
  logic [`FP_AW-1:0]    exp_rd;
  logic                 exp_nv;
  logic                 exp_valid;
  logic                 exp_ready;
  logic                 prev_stall;
  logic [`FP_XLEN-1:0]  prev_data;
  logic [`FP_AW-1:0]    prev_rd;

  // Mode 0 keeps resp_ready high, mode 1 randomizes it and mode 2 holds it low
  int ready_mode;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  fp_subsys u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .issue_op       (issue_op),
    .issue_rd       (issue_rd),
    .issue_rs1      (issue_rs1),
    .issue_rs2      (issue_rs2),
    .issue_int_data (issue_int_data),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_rd        (resp_rd),
    .resp_data      (resp_data),
    .dbg_addr       (dbg_addr),
    .dbg_data       (dbg_data),
    .status_clr     (status_clr),
    .flags          (flags),
    .retired_count  (retired_count)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is %h, expected %h", name, actual, expected);
      abort_run("Value mismatch detected");
    end
  endtask

  function automatic logic word_is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic word_is_snan(input logic [31:0] x);
    return word_is_nan(x) && !x[22];
  endfunction

  // Maps a float to an unsigned key that sorts in IEEE order with -0 below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  // Expected {nv, result} of one operation
  function automatic logic [32:0] fp_ref_op(input fp_pkg::fp_op_e op,
                                            input logic [31:0] a,
                                            input logic [31:0] b,
                                            input logic [31:0] int_data);
    logic [31:0] res;
    logic        nv;
    logic        a_nan;
    logic        b_nan;
    res   = 32'd0;
    nv    = 1'b0;
    a_nan = word_is_nan(a);
    b_nan = word_is_nan(b);
    case (op)
      fp_pkg::OP_FMV_W_X: res = int_data;
      fp_pkg::OP_FSGNJ:   res = {b[31], a[30:0]};
      fp_pkg::OP_FSGNJN:  res = {!b[31], a[30:0]};
      fp_pkg::OP_FSGNJX:  res = {a[31] ^ b[31], a[30:0]};
      default: begin
        nv = word_is_snan(a) || word_is_snan(b);
        if (a_nan && b_nan) begin
          res = `FP_CANON_NAN;
        end else if (a_nan) begin
          res = b;
        end else if (b_nan) begin
          res = a;
        end else if (op == fp_pkg::OP_FMIN) begin
          res = (order_key(a) < order_key(b)) ? a : b;
        end else begin
          res = (order_key(a) > order_key(b)) ? a : b;
        end
      end
    endcase
    return {nv, res};
  endfunction

  // Random value with an exponent below all ones
  function automatic logic [31:0] rand_finite();
    logic [7:0] exp_field;
    exp_field = 8'($urandom_range(0, 254));
    return {1'($urandom_range(0, 1)), exp_field, 23'($urandom)};
  endfunction

  // Drives one operation and waits for its acceptance edge
  task automatic send_op(input fp_pkg::fp_op_e op, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [31:0] int_data, output int stalls);
    logic [32:0] exp;
    logic        accepted;
    int          waited;
    @(negedge clk);
    issue_valid    = 1'b1;
    issue_op       = op;
    issue_rd       = rd;
    issue_rs1      = rs1;
    issue_rs2      = rs2;
    issue_int_data = int_data;
    accepted = 1'b0;
    waited   = 0;
    while (!accepted) begin
      @(posedge clk);
      if (issue_ready) begin
        accepted = 1'b1;
      end else begin
        waited++;
        if (waited > TIMEOUT_CYCLES) abort_run("Issue port never became ready");
      end
    end
    exp = fp_ref_op(op, shadow[rs1], shadow[rs2], int_data);
    exp_data_q.push_back(exp[31:0]);
    exp_rd_q.push_back(rd);
    exp_nv_q.push_back(exp[32]);
    shadow[rd] = exp[31:0];
    stalls = waited;
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    int stalls;
    send_op(fp_pkg::OP_FMV_W_X, rd, 5'd0, 5'd0, value, stalls);
  endtask

  task automatic drain();
    int waited;
    @(negedge clk);
    issue_valid = 1'b0;
    waited = 0;
    while (exp_data_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) abort_run("Pending responses never retired");
    end
  endtask

  task automatic dbg_check(input logic [4:0] addr, input logic [31:0] expected);
    @(negedge clk);
    dbg_addr = addr;
    @(posedge clk);
    check_eq("dbg_data", dbg_data, expected);
  endtask

  task automatic clear_status();
    @(negedge clk);
    status_clr = 1'b1;
    @(negedge clk);
    status_clr = 1'b0;
  endtask

  always @(negedge clk) begin
    case (ready_mode)
      0:       resp_ready = 1'b1;
      1:       resp_ready = 1'($urandom_range(0, 1));
      default: resp_ready = 1'b0;
    endcase
  end

  // Scoreboard samples at the rising edge before any register updates
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_flags  = '0;
      exp_count  = '0;
      exp_valid  = 1'b0;
      prev_stall = 1'b0;
    end else begin
      // Stage occupancy comes from the model, not from the DUT
      exp_ready = !exp_valid || resp_ready;
      check_eq("flags", flags, exp_flags);
      check_eq("retired_count", retired_count, exp_count);
      check_eq("resp_valid", resp_valid, exp_valid);
      check_eq("issue_ready", issue_ready, exp_ready);
      if (prev_stall) begin
        check_eq("resp_data", resp_data, prev_data);
        check_eq("resp_rd", resp_rd, prev_rd);
      end
      if (exp_valid && resp_ready) begin
        exp_data = exp_data_q.pop_front();
        exp_rd   = exp_rd_q.pop_front();
        exp_nv   = exp_nv_q.pop_front();
        check_eq("resp_data", resp_data, exp_data);
        check_eq("resp_rd", resp_rd, exp_rd);
        exp_count++;
        if (exp_nv) exp_flags[4] = 1'b1;
      end
      // Clear wins over a retire on the same edge
      if (status_clr) begin
        exp_flags = '0;
        exp_count = '0;
      end
      prev_stall = exp_valid && !resp_ready;
      exp_valid  = (issue_valid && exp_ready) || (exp_valid && !resp_ready);
      prev_data  = resp_data;
      prev_rd    = resp_rd;
    end
  end

  initial begin
    int          stalls;
    int          waited;
    logic [4:0]  prev;
    logic [4:0]  rd;
    logic [2:0]  op_val;
    issue_valid    = 1'b0;
    issue_op       = fp_pkg::OP_FMV_W_X;
    issue_rd       = '0;
    issue_rs1      = '0;
    issue_rs2      = '0;
    issue_int_data = '0;
    resp_ready     = 1'b1;
    dbg_addr       = '0;
    status_clr     = 1'b0;
    ready_mode     = 0;
    void'($urandom(32'h96b0));

    waited = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) abort_run("Reset was never released");
    end

    // Move into every register including f0 and read all back
    for (int i = 0; i < `FP_NREGS; i++) begin
      load_reg(5'(i), $urandom);
    end
    drain();
    for (int i = 0; i < `FP_NREGS; i++) begin
      dbg_check(5'(i), shadow[i]);
    end

    // Sign injection on random operands
    for (int i = 0; i < 40; i++) begin
      op_val = 3'($urandom_range(1, 3));
      send_op(fp_pkg::fp_op_e'(op_val), 5'($urandom), 5'($urandom), 5'($urandom),
              32'd0, stalls);
    end
    drain();

    // Directed min/max cases
    load_reg(5'd1, 32'h0000_0000);
    load_reg(5'd2, 32'h8000_0000);
    load_reg(5'd3, 32'h7fc0_0000);
    load_reg(5'd4, 32'h3f80_0000);
    load_reg(5'd5, 32'h7fa0_0000);
    load_reg(5'd6, 32'hffc1_2345);
    send_op(fp_pkg::OP_FMIN, 5'd8, 5'd1, 5'd2, 32'd0, stalls);
    send_op(fp_pkg::OP_FMAX, 5'd9, 5'd2, 5'd1, 32'd0, stalls);
    send_op(fp_pkg::OP_FMIN, 5'd10, 5'd3, 5'd6, 32'd0, stalls);
    send_op(fp_pkg::OP_FMAX, 5'd11, 5'd3, 5'd4, 32'd0, stalls);
    drain();
    dbg_check(5'd8, 32'h8000_0000);
    dbg_check(5'd9, 32'h0000_0000);
    dbg_check(5'd10, `FP_CANON_NAN);
    dbg_check(5'd11, 32'h3f80_0000);
    @(posedge clk);
    check_eq("flags", flags, 5'h00);

    // Signalling NaN raises NV which then stays set
    send_op(fp_pkg::OP_FMIN, 5'd12, 5'd5, 5'd4, 32'd0, stalls);
    drain();
    dbg_check(5'd12, 32'h3f80_0000);
    check_eq("flags", flags, 5'h10);
    send_op(fp_pkg::OP_FMAX, 5'd13, 5'd1, 5'd2, 32'd0, stalls);
    drain();
    @(posedge clk);
    check_eq("flags", flags, 5'h10);

    // Random finite operands
    for (int i = 16; i < 24; i++) begin
      load_reg(5'(i), rand_finite());
    end
    for (int i = 0; i < 20; i++) begin
      op_val = 3'($urandom_range(4, 5));
      send_op(fp_pkg::fp_op_e'(op_val), 5'($urandom_range(24, 31)),
              5'($urandom_range(16, 23)), 5'($urandom_range(16, 23)), 32'd0, stalls);
    end
    drain();

    // Dependent chain at one operation per cycle through the forwarding path
    prev = 5'd1;
    for (int i = 0; i < 16; i++) begin
      op_val = 3'($urandom_range(1, 5));
      rd     = 5'($urandom);
      send_op(fp_pkg::fp_op_e'(op_val), rd, prev, 5'($urandom), 32'd0, stalls);
      check_eq("issue_ready wait cycles", stalls, 0);
      prev = rd;
    end
    drain();

    // Random back-pressure on the response port
    ready_mode = 1;
    clear_status();
    for (int i = 0; i < 60; i++) begin
      op_val = 3'($urandom_range(0, 5));
      send_op(fp_pkg::fp_op_e'(op_val), 5'($urandom), 5'($urandom), 5'($urandom),
              $urandom, stalls);
    end
    drain();
    ready_mode = 0;
    @(posedge clk);
    check_eq("retired_count", retired_count, 60);

    // Host clear on its own and NV set again afterwards
    clear_status();
    @(posedge clk);
    check_eq("flags", flags, 5'h00);
    check_eq("retired_count", retired_count, 0);
    load_reg(5'd4, 32'h3f80_0000);
    load_reg(5'd5, 32'h7fa0_0000);
    send_op(fp_pkg::OP_FMIN, 5'd7, 5'd5, 5'd4, 32'd0, stalls);
    drain();
    @(posedge clk);
    check_eq("flags", flags, 5'h10);
    check_eq("retired_count", retired_count, 3);

    // Stalled response retires on the same edge as the host clear
    ready_mode = 2;
    send_op(fp_pkg::OP_FMAX, 5'd7, 5'd5, 5'd4, 32'd0, stalls);
    @(negedge clk);
    issue_valid = 1'b0;
    @(posedge clk);
    ready_mode = 0;
    @(negedge clk);
    status_clr = 1'b1;
    @(negedge clk);
    status_clr = 1'b0;
    @(posedge clk);
    check_eq("flags", flags, 5'h00);
    check_eq("retired_count", retired_count, 0);

    if (exp_data_q.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run("Operations were left unretired at the end of the run");
    end
  end

endmodule

//--- include/fp_consts.svh
`ifndef FP_CONSTS_SVH
`define FP_CONSTS_SVH

// Single-precision data width
`define FP_XLEN 32

// Register file geometry
`define FP_NREGS 32
`define FP_AW 5

// Width of the retired-operation counter, wraps on overflow
`define FP_CNT_W 16

// Canonical quiet NaN returned when both min/max operands are NaN
`define FP_CANON_NAN 32'h7fc0_0000

`endif

//--- rtl/fp_exec_stage.sv
`timescale 1ns/1ps

module fp_exec_stage (
  input  logic             clk,
  input  logic             rst_n,

  // Issue port
  input  logic             issue_valid,
  output logic             issue_ready,
  input  fp_pkg::fp_op_e   issue_op,
  input  fp_pkg::fp_addr_t issue_rd,
  input  fp_pkg::fp_addr_t issue_rs1,
  input  fp_pkg::fp_addr_t issue_rs2,
  input  fp_pkg::fp_word_t issue_int_data,

  // Response port
  output logic             resp_valid,
  input  logic             resp_ready,
  output fp_pkg::fp_addr_t resp_rd,
  output fp_pkg::fp_word_t resp_data,

  // Operand fetch and datapath result
  output fp_pkg::fp_addr_t rs1_addr,
  output fp_pkg::fp_addr_t rs2_addr,
  input  fp_pkg::fp_word_t res,
  input  logic             res_nv,

  // Writeback and status update
  output logic             wb_en,
  output fp_pkg::fp_addr_t wb_addr,
  output fp_pkg::fp_word_t wb_data,
  output logic             retire,
  output logic             retire_nv
);

  logic accept;
  logic nv_q;

  // Stage is free when empty or draining this cycle
  assign issue_ready = !resp_valid || resp_ready;
  assign accept      = issue_valid && issue_ready;
  assign retire      = resp_valid && resp_ready;

  // Operands are read straight from the issue fields
  assign rs1_addr = issue_rs1;
  assign rs2_addr = issue_rs2;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (accept) begin
      resp_valid <= 1'b1;
    end else if (retire) begin
      resp_valid <= 1'b0;
    end
  end

  // Payload only moves on acceptance, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (accept) begin
      resp_data <= res;
      resp_rd   <= issue_rd;
      nv_q      <= res_nv;
    end
  end

  // Writeback lands on the retire edge, a reader in the same cycle gets it by bypass
  assign wb_en     = retire;
  assign wb_addr   = resp_rd;
  assign wb_data   = resp_data;
  assign retire_nv = retire && nv_q;

  a_resp_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |=>
      resp_valid && $stable(resp_data) && $stable(resp_rd)
  );

  // Only supported opcodes may be issued, and a move needs a known source pattern
  a_issue_legal : assert property (
    @(posedge clk) disable iff (!rst_n)
    issue_valid |->
      (issue_op inside {fp_pkg::OP_FMV_W_X, fp_pkg::OP_FSGNJ, fp_pkg::OP_FSGNJN,
                        fp_pkg::OP_FSGNJX, fp_pkg::OP_FMIN, fp_pkg::OP_FMAX}) &&
      (issue_op != fp_pkg::OP_FMV_W_X || !$isunknown(issue_int_data))
  );

endmodule

//--- rtl/fp_pkg.sv
package fp_pkg;

`include "fp_consts.svh"

  // One FP register value, also used for raw integer bit patterns
  typedef logic [`FP_XLEN-1:0] fp_word_t;

  // Register index
  typedef logic [`FP_AW-1:0] fp_addr_t;

  // Accrued flags, bit 4 down to bit 0 is NV, DZ, OF, UF, NX
  typedef logic [4:0] fp_flags_t;

  // Retired-operation count
  typedef logic [`FP_CNT_W-1:0] fp_cnt_t;

  // Operations handled by the execute block
  typedef enum logic [2:0] {
    OP_FMV_W_X = 3'd0,
    OP_FSGNJ   = 3'd1,
    OP_FSGNJN  = 3'd2,
    OP_FSGNJX  = 3'd3,
    OP_FMIN    = 3'd4,
    OP_FMAX    = 3'd5
  } fp_op_e;

endpackage

//--- rtl/fp_regfile.sv
`timescale 1ns/1ps

`include "fp_consts.svh"

module fp_regfile (
  input  logic             clk,

  input  fp_pkg::fp_addr_t rs1_addr,
  output fp_pkg::fp_word_t rs1_data,

  input  fp_pkg::fp_addr_t rs2_addr,
  output fp_pkg::fp_word_t rs2_data,

  input  fp_pkg::fp_addr_t rs3_addr,
  output fp_pkg::fp_word_t rs3_data,

  input  logic             rd_en,
  input  fp_pkg::fp_addr_t rd_addr,
  input  fp_pkg::fp_word_t rd_data
);

  fp_pkg::fp_word_t regs [`FP_NREGS];

  // Plain flop array, f0 is writable like any other entry
  always_ff @(posedge clk) begin
    if (rd_en) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Returns the pending write data on an address match, else the stored word
  function automatic fp_pkg::fp_word_t read_port(
    input fp_pkg::fp_addr_t addr,
    input fp_pkg::fp_word_t stored,
    input logic             wr_en,
    input fp_pkg::fp_addr_t wr_addr,
    input fp_pkg::fp_word_t wr_data
  );
    fp_pkg::fp_word_t word;
    if (wr_en && (wr_addr == addr)) begin
      word = wr_data;
    end else begin
      word = stored;
    end
    return word;
  endfunction

  // Operand ports used by the execute stage
  always_comb begin
    rs1_data = read_port(rs1_addr, regs[rs1_addr], rd_en, rd_addr, rd_data);
    rs2_data = read_port(rs2_addr, regs[rs2_addr], rd_en, rd_addr, rd_data);
  end

  // Third port, serves the host debug read
  always_comb begin
    rs3_data = read_port(rs3_addr, regs[rs3_addr], rd_en, rd_addr, rd_data);
  end

  // A write with an unknown index would corrupt an arbitrary register
  a_wr_addr_known : assert property (
    @(posedge clk) rd_en |-> !$isunknown(rd_addr)
  );

endmodule

//--- rtl/fp_sgnj_minmax.sv
`timescale 1ns/1ps

`include "fp_consts.svh"

module fp_sgnj_minmax (
  input  fp_pkg::fp_op_e   op,
  input  fp_pkg::fp_word_t a,
  input  fp_pkg::fp_word_t b,
  input  fp_pkg::fp_word_t int_data,
  output fp_pkg::fp_word_t result,
  output logic             nv
);

  // Single-precision field positions
  localparam int SIGN    = `FP_XLEN - 1;
  localparam int EXP_MSB = SIGN - 1;
  localparam int EXP_LSB = 23;
  localparam int QUIET   = EXP_LSB - 1;

  // Exponent all ones with a nonzero mantissa
  function automatic logic is_nan(input fp_pkg::fp_word_t x);
    return (&x[EXP_MSB:EXP_LSB]) && (|x[QUIET:0]);
  endfunction

  // Signalling NaN has the quiet bit clear and some lower mantissa bit set
  function automatic logic is_snan(input fp_pkg::fp_word_t x);
    return (&x[EXP_MSB:EXP_LSB]) && !x[QUIET] && (|x[QUIET-1:0]);
  endfunction

  logic             a_nan;
  logic             b_nan;
  logic             a_snan;
  logic             b_snan;
  logic             a_lt_b;
  fp_pkg::fp_word_t minmax;

  assign a_nan  = is_nan(a);
  assign b_nan  = is_nan(b);
  assign a_snan = is_snan(a);
  assign b_snan = is_snan(b);

  // Ordering of non-NaN values in sign-magnitude form
  // A differing sign decides alone, so -0 sorts below +0
  always_comb begin
    if (a[SIGN] != b[SIGN]) begin
      a_lt_b = a[SIGN];
    end else if (a[SIGN]) begin
      a_lt_b = a[EXP_MSB:0] > b[EXP_MSB:0];
    end else begin
      a_lt_b = a[EXP_MSB:0] < b[EXP_MSB:0];
    end
  end

  // NaN operands are dropped in favour of the other operand
  always_comb begin
    if (a_nan && b_nan) begin
      minmax = `FP_CANON_NAN;
    end else if (a_nan) begin
      minmax = b;
    end else if (b_nan) begin
      minmax = a;
    end else if (op == fp_pkg::OP_FMIN) begin
      minmax = a_lt_b ? a : b;
    end else begin
      minmax = a_lt_b ? b : a;
    end
  end

  // Result select, magnitude always comes from a for sign injection
  always_comb begin
    result = '0;
    nv     = 1'b0;
    case (op)
      fp_pkg::OP_FMV_W_X: begin
        result = int_data;
      end
      fp_pkg::OP_FSGNJ: begin
        result = {b[SIGN], a[EXP_MSB:0]};
      end
      fp_pkg::OP_FSGNJN: begin
        result = {~b[SIGN], a[EXP_MSB:0]};
      end
      fp_pkg::OP_FSGNJX: begin
        result = {a[SIGN] ^ b[SIGN], a[EXP_MSB:0]};
      end
      fp_pkg::OP_FMIN, fp_pkg::OP_FMAX: begin
        result = minmax;
        // Only a signalling NaN raises invalid, quiet NaNs pass silently
        nv     = a_snan | b_snan;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- rtl/fp_status_regs.sv
`timescale 1ns/1ps

module fp_status_regs (
  input  logic              clk,
  input  logic              rst_n,

  // Retire events from the execute stage
  input  logic              retire,
  input  logic              retire_nv,

  // Host access
  input  logic              status_clr,
  output fp_pkg::fp_flags_t flags,
  output fp_pkg::fp_cnt_t   retired_count
);

  // Bit position of the invalid-operation flag
  localparam int NV_BIT = 4;

  // Accrued flags are sticky until the host clears them
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (status_clr) begin
      flags <= '0;
    end else if (retire && retire_nv) begin
      flags[NV_BIT] <= 1'b1;
    end
  end

  // Counts every retired operation, wraps at the top
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retired_count <= '0;
    end else if (status_clr) begin
      // Clear wins over a retire in the same cycle
      retired_count <= '0;
    end else if (retire) begin
      retired_count <= fp_pkg::fp_cnt_t'(retired_count + 1'b1);
    end
  end

endmodule

//--- rtl/fp_subsys.sv
`timescale 1ns/1ps

module fp_subsys (
  input  logic              clk,
  input  logic              rst_n,

  // Issue port
  input  logic              issue_valid,
  output logic              issue_ready,
  input  fp_pkg::fp_op_e    issue_op,
  input  fp_pkg::fp_addr_t  issue_rd,
  input  fp_pkg::fp_addr_t  issue_rs1,
  input  fp_pkg::fp_addr_t  issue_rs2,
  input  fp_pkg::fp_word_t  issue_int_data,

  // Response port
  output logic              resp_valid,
  input  logic              resp_ready,
  output fp_pkg::fp_addr_t  resp_rd,
  output fp_pkg::fp_word_t  resp_data,

  // Host debug read
  input  fp_pkg::fp_addr_t  dbg_addr,
  output fp_pkg::fp_word_t  dbg_data,

  // Host status
  input  logic              status_clr,
  output fp_pkg::fp_flags_t flags,
  output fp_pkg::fp_cnt_t   retired_count
);

  fp_pkg::fp_addr_t rs1_addr;
  fp_pkg::fp_addr_t rs2_addr;
  fp_pkg::fp_word_t rs1_data;
  fp_pkg::fp_word_t rs2_data;
  fp_pkg::fp_word_t res;
  logic             res_nv;
  logic             wb_en;
  fp_pkg::fp_addr_t wb_addr;
  fp_pkg::fp_word_t wb_data;
  logic             retire;
  logic             retire_nv;

  // Port 3 is dedicated to the host debug read
  fp_regfile u_regfile (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs1_data (rs1_data),
    .rs2_addr (rs2_addr),
    .rs2_data (rs2_data),
    .rs3_addr (dbg_addr),
    .rs3_data (dbg_data),
    .rd_en    (wb_en),
    .rd_addr  (wb_addr),
    .rd_data  (wb_data)
  );

  fp_sgnj_minmax u_datapath (
    .op       (issue_op),
    .a        (rs1_data),
    .b        (rs2_data),
    .int_data (issue_int_data),
    .result   (res),
    .nv       (res_nv)
  );

  fp_exec_stage u_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .issue_op       (issue_op),
    .issue_rd       (issue_rd),
    .issue_rs1      (issue_rs1),
    .issue_rs2      (issue_rs2),
    .issue_int_data (issue_int_data),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_rd        (resp_rd),
    .resp_data      (resp_data),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .res            (res),
    .res_nv         (res_nv),
    .wb_en          (wb_en),
    .wb_addr        (wb_addr),
    .wb_data        (wb_data),
    .retire         (retire),
    .retire_nv      (retire_nv)
  );

  fp_status_regs u_status (
    .clk           (clk),
    .rst_n         (rst_n),
    .retire        (retire),
    .retire_nv     (retire_nv),
    .status_clr    (status_clr),
    .flags         (flags),
    .retired_count (retired_count)
  );

endmodule

//--- src.f
+incdir+include
rtl/fp_pkg.sv
rtl/fp_regfile.sv
rtl/fp_sgnj_minmax.sv
rtl/fp_exec_stage.sv
rtl/fp_status_regs.sv
rtl/fp_subsys.sv
dv/tb_clk_gen.sv
dv/tb_fp_subsys.sv
